// File: aud_rec.f
+incdir+common
common/aud_pkg.sv
rtl/aud_ctrl_fsm.sv
rtl/aud_addr_counter.sv
rtl/aud_sample_ram.sv
recorder/aud_i2s_rx.sv
player/aud_i2s_tx.sv
rtl/aud_top.sv
tests/tb_aud_top.sv

// File: Makefile
# Verilator build and run of the voice recorder core testbench

SRCS := $(filter %.sv,$(shell cat aud_rec.f))
HDRS := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_aud_top: aud_rec.f $(SRCS) $(HDRS)
	verilator --binary --timing -Wno-fatal --top-module tb_aud_top -f aud_rec.f

run: obj_dir/Vtb_aud_top
	./obj_dir/Vtb_aud_top | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_aud_top.sv
`timescale 1ns/1ps
`include "aud_consts.svh"

module tb_aud_top;

localparam int SW = `AUD_SAMPLE_W;
localparam int TBL_N = 512;
// frame budget per test
// one frame is 32 bit clocks of 40 ns
localparam int FR_START = 4;
localparam int FR_REC = 44;
localparam int FR_PLAY1 = 50;
localparam int FR_PLAY3 = 26;
localparam int FR_PAUSE = 90;
localparam int FR_MARGIN = 20;
localparam int WATCH_NS = (FR_START + FR_REC + FR_PLAY1 + FR_PLAY3 + FR_PAUSE + FR_MARGIN)
	* 32 * 40;

logic                aud_bclk = 1'b0;
logic                rst_n = 1'b1;
logic                key_rec = 1'b1;
logic                key_play = 1'b1;
logic                key_stop = 1'b1;
logic [2:0]          speed = 3'd1;
logic                lrck = 1'b1;
logic                adc_dat = 1'b0;
logic                dac_dat;
aud_pkg::aud_state_t state;
logic [`AUD_ADDR_W:0] rec_len;

logic [SW-1:0] tbl [TBL_N];
logic [SW-1:0] rec_q [$];
logic [SW-1:0] left_w = '0;
logic [SW-1:0] right_w = '0;
logic [SW-1:0] exp_right = '0;
int            seed = 32'h7bd4fb11;
int            slot_cnt = 0;
int            frame_cnt = 0;
int            cap_count = 0;
int            play_base = 0;
int            exp_count = 0;
int            play_speed = 1;
int            idx;
string         test_name = "reset";

aud_top uut (
	.i_AUD_BCLK(aud_bclk), .i_rst_n(rst_n),
	.i_key_rec(key_rec), .i_key_play(key_play), .i_key_stop(key_stop),
	.i_speed(speed), .i_AUD_ADCLRCK(lrck), .i_AUD_ADCDAT(adc_dat),
	.i_AUD_DACLRCK(lrck), .o_AUD_DACDAT(dac_dat), .o_state(state), .o_rec_len(rec_len)
);

always #20 aud_bclk = ~aud_bclk;

// codec model drives lrck low at slot 0 with the left word on slots 1 to 16
always @(posedge aud_bclk) begin
	lrck <= (slot_cnt >= 16);
	if (slot_cnt >= 1 && slot_cnt <= SW)
		adc_dat <= tbl[frame_cnt % TBL_N][SW - slot_cnt];
	else
		adc_dat <= 1'b0;
	slot_cnt <= (slot_cnt == 31) ? 0 : slot_cnt + 1;
	if (slot_cnt == 31)
		frame_cnt <= frame_cnt + 1;
end

task automatic compare(input string name, input logic [31:0] exp_val,
	input logic [31:0] act_val);
	if (exp_val !== act_val) begin
		$display("mismatch %s: expected %0h, actual %0h", name, exp_val, act_val);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at the first error");
	end
endtask

// expected play word k is read from memory at k times the step
function automatic logic [SW-1:0] expected_sample(input int k, input int spd);
	int step;
	step = (spd == 0) ? 1 : spd;
	return rec_q[k * step];
endfunction

function automatic int expected_count(input int len, input int spd);
	int step;
	step = (spd == 0) ? 1 : spd;
	return (len + step - 1) / step;
endfunction

// dac capture takes left bits on slots 2 to 17 and right bits on the rest
always @(negedge aud_bclk) begin
	if (slot_cnt >= 2 && slot_cnt <= SW + 1)
		left_w = {left_w[SW-2:0], dac_dat};
	else
		right_w = {right_w[SW-2:0], dac_dat};
	if (slot_cnt == SW + 1) begin
		// a frame without a sample carries zero on both channels
		exp_right = '0;
		if (left_w != '0) begin
			idx = cap_count - play_base;
			if (idx >= exp_count) begin
				$display("unexpected sample %h on the DAC during %s", left_w, test_name);
				$display("TESTBENCH FAILED");
				$fatal(1, "DAC sent more samples than were expected");
			end else begin
				exp_right = expected_sample(idx, play_speed);
				compare(test_name, exp_right, left_w);
				cap_count = cap_count + 1;
			end
		end
	end
	if (slot_cnt == 1)
		compare("right channel copy", exp_right, right_w);
end

task automatic wait_frames(input int n);
	repeat (n * 32) @(posedge aud_bclk);
endtask

// keys are active low and pressed in the right half of a frame
task automatic press_key(input int which, output int at_frame);
	@(posedge aud_bclk);
	while (slot_cnt != 24)
		@(posedge aud_bclk);
	at_frame = frame_cnt;
	case (which)
		0: key_rec <= 1'b0;
		1: key_play <= 1'b0;
		default: key_stop <= 1'b0;
	endcase
	repeat (2) @(posedge aud_bclk);
	key_rec <= 1'b1;
	key_play <= 1'b1;
	key_stop <= 1'b1;
endtask

task automatic expect_state(input string name, input aud_pkg::aud_state_t exp_st);
	@(negedge aud_bclk);
	compare(name, exp_st, state);
endtask

task automatic add_frames(input int first, input int last);
	for (int f = first; f <= last; f++)
		rec_q.push_back(tbl[f % TBL_N]);
endtask

task automatic play_and_check(input string name, input int spd, input int pause_at);
	int f;
	@(posedge aud_bclk);
	test_name = name;
	speed <= 3'(spd);
	play_speed = spd;
	exp_count = expected_count(rec_q.size(), spd);
	play_base = cap_count;
	press_key(1, f);
	expect_state({name, " start"}, aud_pkg::ST_PLAY);
	if (pause_at != 0) begin
		wait_frames(pause_at);
		press_key(1, f);
		expect_state({name, " paused"}, aud_pkg::ST_PLAY_PAUSE);
		wait_frames(6);
		press_key(1, f);
		expect_state({name, " resumed"}, aud_pkg::ST_PLAY);
	end
	// play must end on its own
	@(negedge aud_bclk);
	while (state != aud_pkg::ST_IDLE)
		@(negedge aud_bclk);
	wait_frames(4);
	compare({name, " sample count"}, exp_count, cap_count - play_base);
endtask

initial begin
	int fa;
	int fb;
	int fp;
	int fr;
	for (int i = 0; i < TBL_N; i++)
		tbl[i] = SW'($random(seed)) | SW'(1);
	repeat (16) @(posedge aud_bclk);
	rst_n <= 1'b0;

	test_name = "after reset";
	expect_state("state after reset", aud_pkg::ST_IDLE);
	compare("rec_len after reset", 0, rec_len);
	repeat (64) begin
		@(negedge aud_bclk);
		compare("dac idle after reset", 0, dac_dat);
	end

	test_name = "record";
	press_key(0, fa);
	expect_state("record start", aud_pkg::ST_REC);
	wait_frames(39);
	press_key(2, fb);
	expect_state("record stop", aud_pkg::ST_IDLE);
	add_frames(fa + 1, fb);
	compare("record length", rec_q.size(), rec_len);

	play_and_check("play speed 1", 1, 0);
	play_and_check("play speed 3", 3, 0);

	// frames sent during a record pause stay out of memory
	test_name = "record pause";
	rec_q.delete();
	press_key(0, fa);
	expect_state("record pause start", aud_pkg::ST_REC);
	wait_frames(13);
	press_key(0, fp);
	expect_state("record paused", aud_pkg::ST_REC_PAUSE);
	wait_frames(5);
	press_key(0, fr);
	expect_state("record resumed", aud_pkg::ST_REC);
	wait_frames(14);
	press_key(2, fb);
	expect_state("record pause stop", aud_pkg::ST_IDLE);
	add_frames(fa + 1, fp);
	add_frames(fr + 1, fb);
	compare("record length with pause", rec_q.size(), rec_len);

	play_and_check("play pause", 1, 8);

	$display("TESTBENCH PASSED");
	$finish;
end

initial begin
	#(WATCH_NS);
	$display("timeout: the tests did not finish within %0d ns", WATCH_NS);
	$display("TESTBENCH FAILED");
	$fatal(1, "watchdog expired");
end

endmodule

// File: rtl/aud_top.sv
`timescale 1ns/1ps
`include "aud_consts.svh"

module aud_top (
	input  logic                i_AUD_BCLK,
	input  logic                i_rst_n,
	input  logic                i_key_rec,
	input  logic                i_key_play,
	input  logic                i_key_stop,
	input  logic [2:0]          i_speed,
	input  logic                i_AUD_ADCLRCK,
	input  logic                i_AUD_ADCDAT,
	input  logic                i_AUD_DACLRCK,
	output logic                o_AUD_DACDAT,
	output aud_pkg::aud_state_t o_state,
	output logic [`AUD_ADDR_W:0] o_rec_len
);

logic                   rec_en;
logic                   play_en;
logic                   rec_clear;
logic                   play_start;
logic                   rec_full;
logic                   play_done;
logic                   rec_len_nz;
logic                   rx_valid;
logic                   wr_en;
logic                   rd_en;
logic                   rd_valid;
logic                   credit;
logic [`AUD_ADDR_W-1:0] addr;
logic [`AUD_SAMPLE_W-1:0] rx_sample;
aud_pkg::sample_t       rd_data;

aud_ctrl_fsm u_fsm (
	.i_AUD_BCLK(i_AUD_BCLK), .i_rst_n(i_rst_n),
	.i_key_rec(i_key_rec), .i_key_play(i_key_play), .i_key_stop(i_key_stop),
	.i_rec_full(rec_full), .i_play_done(play_done), .i_rec_len_nz(rec_len_nz),
	.o_state(o_state), .o_rec_en(rec_en), .o_play_en(play_en),
	.o_rec_clear(rec_clear), .o_play_start(play_start)
);

aud_addr_counter u_counter (
	.i_AUD_BCLK(i_AUD_BCLK), .i_rst_n(i_rst_n), .i_speed(i_speed),
	.i_rec_en(rec_en), .i_rec_clear(rec_clear),
	.i_play_en(play_en), .i_play_start(play_start),
	.i_rx_valid(rx_valid), .i_credit(credit), .i_rd_valid(rd_valid),
	.o_wr_en(wr_en), .o_rd_en(rd_en), .o_addr(addr), .o_rec_len(o_rec_len),
	.o_rec_len_nz(rec_len_nz), .o_rec_full(rec_full), .o_play_done(play_done)
);

aud_sample_ram u_ram (
	.i_AUD_BCLK(i_AUD_BCLK), .i_wr_en(wr_en), .i_rd_en(rd_en),
	.i_addr(addr), .i_wr_data(rx_sample),
	.o_rd_data(rd_data), .o_rd_valid(rd_valid)
);

aud_i2s_rx u_rx (
	.i_AUD_BCLK(i_AUD_BCLK), .i_rst_n(i_rst_n),
	.i_AUD_ADCLRCK(i_AUD_ADCLRCK), .i_AUD_ADCDAT(i_AUD_ADCDAT),
	.o_sample(rx_sample), .o_valid(rx_valid)
);

aud_i2s_tx u_tx (
	.i_AUD_BCLK(i_AUD_BCLK), .i_rst_n(i_rst_n), .i_AUD_DACLRCK(i_AUD_DACLRCK),
	.i_wr_valid(rd_valid), .i_wr_data(rd_data),
	.o_AUD_DACDAT(o_AUD_DACDAT), .o_credit(credit)
);

endmodule

// File: player/aud_i2s_tx.sv
`timescale 1ns/1ps
`include "aud_consts.svh"

module aud_i2s_tx (
	input  logic             i_AUD_BCLK,
	input  logic             i_rst_n,
	input  logic             i_AUD_DACLRCK,
	input  logic             i_wr_valid,
	input  aud_pkg::sample_t i_wr_data,
	output logic             o_AUD_DACDAT,
	output logic             o_credit
);

localparam int DEPTH = `AUD_CREDITS;
localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int NW    = $clog2(DEPTH + 1);
localparam int BW    = $clog2(`AUD_SAMPLE_W + 1);

aud_pkg::sample_t fifo [DEPTH];
aud_pkg::sample_t hold_r;
aud_pkg::sample_t cur_r;
aud_pkg::sample_t sh_r;

logic [PW-1:0] wr_ptr;
logic [PW-1:0] rd_ptr;
logic [NW-1:0] count;
logic [BW-1:0] bits_left;
logic          lrck_d;
logic          lr_fall;
logic          lr_rise;
logic          pop;

assign lr_fall = lrck_d & ~i_AUD_DACLRCK;
assign lr_rise = ~lrck_d & i_AUD_DACLRCK;
assign pop     = lr_fall & (count != '0);

// line idles low once the word is out
assign o_AUD_DACDAT = (bits_left != '0) ? sh_r[`AUD_SAMPLE_W-1] : 1'b0;

always_ff @(posedge i_AUD_BCLK) begin
	if (i_wr_valid)
		fifo[wr_ptr] <= i_wr_data;
end

always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		lrck_d    <= 1'b0;
		wr_ptr    <= '0;
		rd_ptr    <= '0;
		count     <= '0;
		o_credit  <= 1'b0;
		hold_r    <= '0;
		cur_r     <= '0;
		sh_r      <= '0;
		bits_left <= '0;
	end else begin
		lrck_d   <= i_AUD_DACLRCK;
		o_credit <= pop;
		count    <= count + NW'(i_wr_valid) - NW'(pop);
		if (i_wr_valid)
			wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		if (lr_fall) begin
			// word popped last frame goes out now, empty buffer sends zero
			cur_r  <= hold_r;
			sh_r   <= hold_r;
			hold_r <= pop ? fifo[rd_ptr] : '0;
		end else if (lr_rise) begin
			// right channel repeats the left word
			sh_r <= cur_r;
		end else if (bits_left != '0) begin
			sh_r <= sh_r << 1;
		end
		if (lr_fall || lr_rise)
			bits_left <= BW'(`AUD_SAMPLE_W);
		else if (bits_left != '0)
			bits_left <= bits_left - 1'b1;
	end
end

endmodule

// File: recorder/aud_i2s_rx.sv
`timescale 1ns/1ps
`include "aud_consts.svh"

module aud_i2s_rx (
	input  logic                    i_AUD_BCLK,
	input  logic                    i_rst_n,
	input  logic                    i_AUD_ADCLRCK,
	input  logic                    i_AUD_ADCDAT,
	output logic [`AUD_SAMPLE_W-1:0] o_sample,
	output logic                    o_valid
);

localparam int BW = $clog2(`AUD_SAMPLE_W);

logic                     lrck_d;
logic                     active;
logic [BW-1:0]            bit_cnt;
logic [`AUD_SAMPLE_W-1:0] shift_r;

assign o_sample = shift_r;

// falling lrck starts the left word, msb comes one bclk later
always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		lrck_d  <= 1'b0;
		active  <= 1'b0;
		bit_cnt <= '0;
		o_valid <= 1'b0;
	end else begin
		lrck_d  <= i_AUD_ADCLRCK;
		o_valid <= 1'b0;
		if (lrck_d && !i_AUD_ADCLRCK) begin
			active  <= 1'b1;
			bit_cnt <= '0;
		end else if (active) begin
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == BW'(`AUD_SAMPLE_W - 1)) begin
				active  <= 1'b0;
				o_valid <= 1'b1;
			end
		end
	end
end

always_ff @(posedge i_AUD_BCLK) begin
	if (active)
		shift_r <= {shift_r[`AUD_SAMPLE_W-2:0], i_AUD_ADCDAT};
end

endmodule

// File: rtl/aud_sample_ram.sv
`timescale 1ns/1ps
`include "aud_consts.svh"

module aud_sample_ram (
	input  logic                   i_AUD_BCLK,
	input  logic                   i_wr_en,
	input  logic                   i_rd_en,
	input  logic [`AUD_ADDR_W-1:0] i_addr,
	input  aud_pkg::sample_t       i_wr_data,
	output aud_pkg::sample_t       o_rd_data,
	output logic                   o_rd_valid
);

aud_pkg::sample_t mem [`AUD_MEM_DEPTH];

// single port, write and read never overlap
always_ff @(posedge i_AUD_BCLK) begin
	if (i_wr_en)
		mem[i_addr] <= i_wr_data;
	if (i_rd_en)
		o_rd_data <= mem[i_addr];
end

// data valid one cycle after the read
always_ff @(posedge i_AUD_BCLK) begin
	o_rd_valid <= i_rd_en;
end

endmodule

// File: rtl/aud_addr_counter.sv
`timescale 1ns/1ps
`include "aud_consts.svh"

module aud_addr_counter (
	input  logic                  i_AUD_BCLK,
	input  logic                  i_rst_n,
	input  logic [2:0]            i_speed,
	input  logic                  i_rec_en,
	input  logic                  i_rec_clear,
	input  logic                  i_play_en,
	input  logic                  i_play_start,
	input  logic                  i_rx_valid,
	input  logic                  i_credit,
	input  logic                  i_rd_valid,
	output logic                  o_wr_en,
	output logic                  o_rd_en,
	output logic [`AUD_ADDR_W-1:0] o_addr,
	output logic [`AUD_ADDR_W:0]  o_rec_len,
	output logic                  o_rec_len_nz,
	output logic                  o_rec_full,
	output logic                  o_play_done
);

localparam int CW = $clog2(`AUD_CREDITS + 1);

logic [`AUD_ADDR_W:0] wr_ptr;
logic [`AUD_ADDR_W:0] wr_base;
logic [`AUD_ADDR_W:0] play_ptr;
logic [`AUD_ADDR_W:0] play_next;
logic [2:0]           step;
logic [CW-1:0]        credits;
logic                 play_last;

// a sample may land in the same cycle as the clear
assign wr_base    = i_rec_clear ? '0 : wr_ptr;
assign o_wr_en    = i_rec_en & i_rx_valid & ~wr_base[`AUD_ADDR_W];
assign o_rec_full = o_wr_en & (wr_base == `AUD_MEM_DEPTH - 1);

// speed 0 steps like speed 1
assign step      = (i_speed == 3'd0) ? 3'd1 : i_speed;
assign play_next = play_ptr + {{(`AUD_ADDR_W - 2){1'b0}}, step};

assign o_rd_en = i_play_en & ~i_play_start & ~play_last & (credits != '0);
assign o_addr  = i_rec_en ? wr_base[`AUD_ADDR_W-1:0] : play_ptr[`AUD_ADDR_W-1:0];

assign o_rec_len    = wr_ptr;
assign o_rec_len_nz = (wr_ptr != '0);
// only the final read can return once play_last is set
assign o_play_done  = i_rd_valid & play_last;

always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		wr_ptr    <= '0;
		play_ptr  <= '0;
		credits   <= CW'(`AUD_CREDITS);
		play_last <= 1'b0;
	end else begin
		wr_ptr <= wr_base + {{`AUD_ADDR_W{1'b0}}, o_wr_en};
		if (i_play_start) begin
			play_ptr  <= '0;
			credits   <= CW'(`AUD_CREDITS);
			play_last <= 1'b0;
		end else begin
			credits <= credits - CW'(o_rd_en) + CW'(i_credit);
			if (o_rd_en) begin
				if (play_next >= wr_ptr)
					play_last <= 1'b1;
				else
					play_ptr <= play_next;
			end
		end
	end
end

endmodule

// File: rtl/aud_ctrl_fsm.sv
`timescale 1ns/1ps
`include "aud_consts.svh"

module aud_ctrl_fsm (
	input  logic                i_AUD_BCLK,
	input  logic                i_rst_n,
	input  logic                i_key_rec,
	input  logic                i_key_play,
	input  logic                i_key_stop,
	input  logic                i_rec_full,
	input  logic                i_play_done,
	input  logic                i_rec_len_nz,
	output aud_pkg::aud_state_t o_state,
	output logic                o_rec_en,
	output logic                o_play_en,
	output logic                o_rec_clear,
	output logic                o_play_start
);

aud_pkg::aud_state_t state_r, state_w;

logic key_rec_r;
logic key_play_r;
logic key_stop_r;
logic rec_press;
logic play_press;
logic stop_press;
logic rec_clear_r;
logic play_start_r;

// a press is a 1-to-0 change between two clocks
assign rec_press  = key_rec_r & ~i_key_rec;
assign play_press = key_play_r & ~i_key_play;
assign stop_press = key_stop_r & ~i_key_stop;

assign o_state      = state_r;
assign o_rec_en     = (state_r == aud_pkg::ST_REC);
assign o_play_en    = (state_r == aud_pkg::ST_PLAY);
assign o_rec_clear  = rec_clear_r;
assign o_play_start = play_start_r;

always_comb begin
	state_w = state_r;
	case (state_r)
		aud_pkg::ST_IDLE: begin
			if (rec_press)
				state_w = aud_pkg::ST_REC;
			// nothing to play back without a recording
			else if (play_press && i_rec_len_nz)
				state_w = aud_pkg::ST_PLAY;
		end
		aud_pkg::ST_REC: begin
			if (stop_press || i_rec_full)
				state_w = aud_pkg::ST_IDLE;
			else if (rec_press)
				state_w = aud_pkg::ST_REC_PAUSE;
		end
		aud_pkg::ST_REC_PAUSE: begin
			if (stop_press)
				state_w = aud_pkg::ST_IDLE;
			else if (rec_press)
				state_w = aud_pkg::ST_REC;
		end
		aud_pkg::ST_PLAY, aud_pkg::ST_PLAY_PAUSE: begin
			// last read may return just after a pause
			if (stop_press || i_play_done)
				state_w = aud_pkg::ST_IDLE;
			else if (play_press)
				state_w = (state_r == aud_pkg::ST_PLAY) ? aud_pkg::ST_PLAY_PAUSE
				                                        : aud_pkg::ST_PLAY;
		end
		default: state_w = aud_pkg::ST_IDLE;
	endcase
end

always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		state_r      <= aud_pkg::ST_IDLE;
		key_rec_r    <= 1'b0;
		key_play_r   <= 1'b0;
		key_stop_r   <= 1'b0;
		rec_clear_r  <= 1'b0;
		play_start_r <= 1'b0;
	end else begin
		state_r      <= state_w;
		key_rec_r    <= i_key_rec;
		key_play_r   <= i_key_play;
		key_stop_r   <= i_key_stop;
		rec_clear_r  <= (state_r == aud_pkg::ST_IDLE) && (state_w == aud_pkg::ST_REC);
		play_start_r <= (state_r == aud_pkg::ST_IDLE) && (state_w == aud_pkg::ST_PLAY);
	end
end

endmodule

// File: common/aud_pkg.sv
`include "aud_consts.svh"

package aud_pkg;

	// one audio sample word
	typedef logic [`AUD_SAMPLE_W-1:0] sample_t;

	// record/play control states
	typedef enum logic [2:0] {
		ST_IDLE       = 3'd0,
		ST_REC        = 3'd1,
		ST_REC_PAUSE  = 3'd2,
		ST_PLAY       = 3'd3,
		ST_PLAY_PAUSE = 3'd4
	} aud_state_t;

endpackage

// File: common/aud_consts.svh
`ifndef AUD_CONSTS_SVH
`define AUD_CONSTS_SVH

// width of one audio sample
`define AUD_SAMPLE_W 16

// sample memory geometry
`define AUD_ADDR_W 10
`define AUD_MEM_DEPTH 1024

// transmitter buffer slots, also the initial credit count
`define AUD_CREDITS 2

`endif
